// ==== Bender.yml ====
package:
  name: b200_ctrl

sources:
  - files:
      - common/b200_ctrl_pkg.sv
      - pps_timing/pps_timing.sv
      - hdl/status_capture.sv
      - hdl/readback_mux.sv
      - hdl/wb_setting_regs.sv
      - hdl/b200_ctrl_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/b200_ctrl_tb.sv

// ==== common/b200_ctrl_pkg.sv ====
// Control-plane package for the two-channel radio core
// Register map, compat constants, PPS source encoding and bus structs

`default_nettype none

package b200_ctrl_pkg;

    //////////////////////////////////////////////////
    // Wishbone geometry
    //////////////////////////////////////////////////
    localparam int WB_ADDR_W = 3;   // Word address
    localparam int WB_DATA_W = 32;

    // Register word addresses
    typedef enum logic [WB_ADDR_W-1:0] {
        REG_MISC     = 3'd0,
        REG_RB_SEL   = 3'd1,
        REG_GPSDO_ST = 3'd2,
        REG_PPS_SEL  = 3'd3,
        REG_RB_LO    = 3'd4,        // Read only
        REG_RB_HI    = 3'd5         // Read only
    } reg_addr_e;

    // PPS source select
    typedef enum logic [1:0] {
        PPS_GPSDO = 2'd0,
        PPS_EXT   = 2'd1,
        PPS_INT   = 2'd2,
        PPS_OFF   = 2'd3
    } pps_src_e;

    //////////////////////////////////////////////////
    // Readback constants
    //////////////////////////////////////////////////
    localparam logic [31:0] RB_SIGNATURE = 32'hACE0BA5E;
    localparam logic [15:0] COMPAT_MAJOR = 16'h0004;
    localparam logic [15:0] COMPAT_MINOR = 16'h0000;
    localparam logic [7:0]  RADIO_COUNT  = 8'd1;   // Single radio build

    // Internal PPS period, short so simulation sees many pulses
    localparam logic [31:0] PPS_PERIOD_CYCLES = 32'd100;

    //////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////

    // Settings seen by the rest of the core
    typedef struct packed {
        logic [31:0] misc;
        logic [1:0]  rb_sel;
        logic [7:0]  gpsdo_st;
        pps_src_e    pps_sel;
    } core_settings_t;

    // Host side of the Wishbone classic port
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    // Captured status for readback
    typedef struct packed {
        logic [1:0]  lock;       // After two-flop sync
        logic [31:0] misc_in;
        logic [31:0] pps_count;
    } status_t;

endpackage

`default_nettype wire

// ==== filelist.f ====
+incdir+tests
common/b200_ctrl_pkg.sv
pps_timing/pps_timing.sv
hdl/status_capture.sv
hdl/readback_mux.sv
hdl/wb_setting_regs.sv
hdl/b200_ctrl_top.sv
tests/b200_ctrl_tb.sv

// ==== hdl/b200_ctrl_top.sv ====
// Control-plane top for the two-channel radio
// Register block, PPS path, status capture and readback word

`timescale 1ns/1ps
`default_nettype none

module b200_ctrl_top (
    input  wire                                  radio_clk,
    input  wire                                  bus_rst,
    input  wire  b200_ctrl_pkg::wb_req_t         i_wb,
    input  wire                                  i_pps_gpsdo,
    input  wire                                  i_pps_ext,
    input  wire  [1:0]                           i_lock,
    input  wire  [31:0]                          i_misc_in,
    output logic [b200_ctrl_pkg::WB_DATA_W-1:0]  o_wb_dat,
    output logic                                 o_wb_ack,
    output logic [31:0]                          o_misc,
    output logic                                 o_pps
);
    import b200_ctrl_pkg::*;

    core_settings_t settings;
    status_t        status;
    logic [31:0]    pps_count;
    logic [63:0]    rb_word;

    // Host registers
    wb_setting_regs wb_setting_regs_i (
        .radio_clk  (radio_clk),
        .bus_rst    (bus_rst),
        .i_wb       (i_wb),
        .i_rb_word  (rb_word),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_settings (settings)
    );

    pps_timing pps_timing_i (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_pps_gpsdo (i_pps_gpsdo),
        .i_pps_ext   (i_pps_ext),
        .i_pps_sel   (settings.pps_sel),
        .o_pps       (o_pps),
        .o_pps_count (pps_count)
    );

    status_capture status_capture_i (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_lock      (i_lock),
        .i_misc_in   (i_misc_in),
        .i_pps_count (pps_count),
        .o_status    (status)
    );

    readback_mux readback_mux_i (
        .i_rb_sel   (settings.rb_sel),
        .i_gpsdo_st (settings.gpsdo_st),
        .i_status   (status),
        .o_rb_word  (rb_word)
    );

    assign o_misc = settings.misc;  // Misc output word to the board

endmodule

`default_nettype wire

// ==== hdl/readback_mux.sv ====
// Readback mux that builds the 64-bit word picked by the readback select

`timescale 1ns/1ps
`default_nettype none

module readback_mux (
    input  wire  [1:0]              i_rb_sel,
    input  wire  [7:0]              i_gpsdo_st,
    input  wire  b200_ctrl_pkg::status_t i_status,
    output logic [63:0]             o_rb_word
);
    import b200_ctrl_pkg::*;

    //////////////////////////////////////////////////
    // Word select
    //////////////////////////////////////////////////
    always_comb begin
        case (i_rb_sel)
            2'd0: o_rb_word = {RB_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1: o_rb_word = {32'd0, i_status.pps_count};   // Edge count
            2'd2: o_rb_word = {16'd0, RADIO_COUNT, i_gpsdo_st, i_status.misc_in};
            default: begin
                o_rb_word = {62'd0, i_status.lock};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/status_capture.sv ====
// Status capture: lock bit sync and registered misc input

`timescale 1ns/1ps
`default_nettype none

module status_capture (
    input  wire                     radio_clk,
    input  wire                     bus_rst,
    input  wire  [1:0]              i_lock,
    input  wire  [31:0]             i_misc_in,
    input  wire  [31:0]             i_pps_count,
    output b200_ctrl_pkg::status_t  o_status
);
    import b200_ctrl_pkg::*;

    logic [1:0]  lock_meta;
    logic [1:0]  lock_sync;
    logic [31:0] misc_q;

    // Front-end lock bits are asynchronous to radio_clk
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
            misc_q    <= '0;
        end else begin
            lock_meta <= i_lock;
            lock_sync <= lock_meta;
            misc_q    <= i_misc_in;   // Single capture stage
        end
    end

    assign o_status = '{
        lock:      lock_sync,
        misc_in:   misc_q,
        pps_count: i_pps_count
    };

endmodule

`default_nettype wire

// ==== hdl/wb_setting_regs.sv ====
// Wishbone classic slave for the core setting registers
// One-cycle registered ack, read data returned in the ack cycle

`timescale 1ns/1ps
`default_nettype none

module wb_setting_regs (
    input  wire                                  radio_clk,
    input  wire                                  bus_rst,
    input  wire  b200_ctrl_pkg::wb_req_t         i_wb,
    input  wire  [63:0]                          i_rb_word,
    output logic [b200_ctrl_pkg::WB_DATA_W-1:0]  o_wb_dat,
    output logic                                 o_wb_ack,
    output b200_ctrl_pkg::core_settings_t        o_settings
);
    import b200_ctrl_pkg::*;

    logic                 req;
    logic                 accept;
    logic                 wr_en;
    reg_addr_e            addr;
    logic [WB_DATA_W-1:0] rd_data;

    logic [31:0] misc_r;
    logic [1:0]  rb_sel_r;
    logic [7:0]  gpsdo_st_r;
    pps_src_e    pps_sel_r;

    assign req    = i_wb.cyc & i_wb.stb;
    assign accept = req & ~o_wb_ack;   // Request still held in ack cycle
    assign wr_en  = accept & i_wb.we;
    assign addr   = reg_addr_e'(i_wb.adr);

    //////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////
    always_comb begin
        rd_data = '0;   // Unmapped reads as zero
        case (addr)
            REG_MISC:     rd_data = misc_r;
            REG_RB_SEL:   rd_data = {30'd0, rb_sel_r};
            REG_GPSDO_ST: rd_data = {24'd0, gpsdo_st_r};
            REG_PPS_SEL:  rd_data = {30'd0, pps_sel_r};
            REG_RB_LO:    rd_data = i_rb_word[31:0];
            REG_RB_HI:    rd_data = i_rb_word[63:32];
            default:      rd_data = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Ack and resettable settings
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_wb_ack  <= 1'b0;
            misc_r    <= '0;
            rb_sel_r  <= '0;
            pps_sel_r <= PPS_GPSDO;
        end else begin
            o_wb_ack <= accept;
            if (wr_en) begin
                case (addr)
                    REG_MISC:    misc_r    <= i_wb.dat;
                    REG_RB_SEL:  rb_sel_r  <= i_wb.dat[1:0];
                    REG_PPS_SEL: pps_sel_r <= pps_src_e'(i_wb.dat[1:0]);
                    default:     ;   // Readback words ignore writes
                endcase
            end
        end
    end

    // GPSDO status survives a bus reset
    always_ff @(posedge radio_clk) begin
        if (wr_en && addr == REG_GPSDO_ST) begin
            gpsdo_st_r <= i_wb.dat[7:0];
        end
        if (accept) begin
            o_wb_dat <= rd_data;   // Valid with ack
        end
    end

    assign o_settings = '{
        misc:     misc_r,
        rb_sel:   rb_sel_r,
        gpsdo_st: gpsdo_st_r,
        pps_sel:  pps_sel_r
    };

    // Host holding stb across the ack cycle must not get a second ack
    a_single_ack: assert property (@(posedge radio_clk) disable iff (bus_rst)
        (o_wb_ack && i_wb.stb) |=> !(o_wb_ack && i_wb.stb));

    a_ack_after_req: assert property (@(posedge radio_clk) disable iff (bus_rst)
        o_wb_ack |-> $past(i_wb.cyc && i_wb.stb));

endmodule

`default_nettype wire

// ==== pps_timing/pps_timing.sv ====
// PPS path: internal pulse generator, source synchronizers,
// source select and a counter of selected PPS rising edges

`timescale 1ns/1ps
`default_nettype none

module pps_timing (
    input  wire                          radio_clk,
    input  wire                          bus_rst,
    input  wire                          i_pps_gpsdo,
    input  wire                          i_pps_ext,
    input  wire  b200_ctrl_pkg::pps_src_e i_pps_sel,
    output logic                         o_pps,
    output logic [31:0]                  o_pps_count
);
    import b200_ctrl_pkg::*;

    logic [31:0] period_cnt;
    logic        period_wrap;
    logic        int_pps;

    logic [2:0]  meta_q;   // {int, ext, gpsdo}
    logic [2:0]  sync_q;
    logic        pps_d;

    //////////////////////////////////////////////////
    // Internal PPS
    //////////////////////////////////////////////////
    assign period_wrap = (period_cnt == PPS_PERIOD_CYCLES - 32'd1);

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            period_cnt <= '0;
            int_pps    <= 1'b0;
        end else begin
            int_pps    <= period_wrap;   // One cycle per period
            period_cnt <= period_wrap ? '0 : period_cnt + 32'd1;
        end
    end

    //////////////////////////////////////////////////
    // Source synchronizers and select
    //////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= {int_pps, i_pps_ext, i_pps_gpsdo};
            sync_q <= meta_q;
        end
    end

    always_comb begin
        case (i_pps_sel)
            PPS_GPSDO: o_pps = sync_q[0];
            PPS_EXT:   o_pps = sync_q[1];
            PPS_INT:   o_pps = sync_q[2];
            default:   o_pps = 1'b0;   // PPS_OFF
        endcase
    end

    // Rising edge counter for readback
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            pps_d       <= 1'b0;
            o_pps_count <= '0;
        end else begin
            pps_d <= o_pps;
            if (o_pps && !pps_d) begin
                o_pps_count <= o_pps_count + 32'd1;
            end
        end
    end

    a_int_pps_single: assert property (@(posedge radio_clk) disable iff (bus_rst)
        int_pps |=> !int_pps);

endmodule

`default_nettype wire

// ==== tests/b200_ctrl_checks.svh ====
// Testbench helpers for the radio control-plane core
// Readback reference model, value check and Wishbone host tasks

`ifndef B200_CTRL_CHECKS_SVH
`define B200_CTRL_CHECKS_SVH

// Expected readback word, built from the register map rules
function automatic logic [63:0] expected_readback(
    input logic [1:0]     sel,
    input core_settings_t cfg,
    input logic [1:0]     lock_bits,
    input logic [31:0]    misc_word,
    input logic [31:0]    pps_cnt
);
    logic [63:0] word;
    case (sel)
        2'd0:    word = {32'hACE0_BA5E, 16'd4, 16'd0};   // Signature, major, minor
        2'd1:    word = {32'd0, pps_cnt};
        2'd2:    word = {16'd0, 8'd1, cfg.gpsdo_st, misc_word};
        default: word = {62'd0, lock_bits};
    endcase
    return word;
endfunction

task automatic compare_value(input string test_name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
        error_count++;
        $display("FAILED %s expected %h actual %h", test_name, expected, actual);
        $display("Simulation FAILED");
        $fatal(1, "Value mismatch in %s", test_name);
    end
endtask

task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "%s", what);
endtask

// Hand a result to the compare process
task automatic queue_check(input string test_name, input logic [63:0] expected,
                           input logic [63:0] actual);
    name_q.push_back(test_name);
    exp_q.push_back(expected);
    act_q.push_back(actual);
endtask

//////////////////////////////////////////////////
// Wishbone classic host
//////////////////////////////////////////////////
task automatic bus_access(input logic we, input reg_addr_e addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int wait_cycles;
    int acks_before;
    wait_cycles = 0;
    @(posedge radio_clk);
    #DRIVE_DLY;
    acks_before = ack_seen;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdata};
    @(negedge radio_clk);
    while (!wb_ack) begin
        wait_cycles++;
        if (wait_cycles > ACK_TIMEOUT) begin
            report_failure($sformatf("No Wishbone ack within %0d cycles", ACK_TIMEOUT));
        end
        @(negedge radio_clk);
    end
    rdata = wb_dat;   // Data valid in ack cycle
    @(posedge radio_clk);
    #DRIVE_DLY;
    wb_req = '0;
    @(negedge radio_clk);
    #1;
    queue_check("ack count", 64'd1, ack_seen - acks_before);
endtask

task automatic bus_write(input reg_addr_e addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
endtask

task automatic bus_read(input reg_addr_e addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'd0, data);
endtask

task automatic write_and_verify(input reg_addr_e addr, input logic [31:0] data,
                                input logic [31:0] mask, input string test_name);
    logic [31:0] rd;
    bus_write(addr, data);
    bus_read(addr, rd);
    queue_check(test_name, data & mask, rd);
endtask

// Select a readback word and fetch both halves
task automatic read_rb_word(input logic [1:0] sel, output logic [63:0] word);
    logic [31:0] hi;
    logic [31:0] lo;
    bus_write(REG_RB_SEL, {30'd0, sel});
    model.rb_sel = sel;
    bus_read(REG_RB_HI, hi);
    bus_read(REG_RB_LO, lo);
    word = {hi, lo};
endtask

// Single-cycle pulses, five cycles low between them
task automatic drive_pulses(input logic on_ext, input int count);
    for (int k = 0; k < count; k++) begin
        @(posedge radio_clk);
        #DRIVE_DLY;
        if (on_ext) pps_ext = 1'b1;
        else        pps_gpsdo = 1'b1;
        @(posedge radio_clk);
        #DRIVE_DLY;
        pps_ext   = 1'b0;
        pps_gpsdo = 1'b0;
        repeat (4) @(posedge radio_clk);
    end
endtask

`endif

// ==== tests/b200_ctrl_tb.sv ====
// Testbench for the radio control-plane core
// Register access, readback words and PPS source behavior

`timescale 1ns/1ps
`default_nettype none

module b200_ctrl_tb;
    import b200_ctrl_pkg::*;

    localparam time CLK_PERIOD  = 40ns;
    localparam time DRIVE_DLY   = 2ns;
    localparam int  NUM_TESTS   = 6;
    localparam int  ACK_TIMEOUT = 20;

    logic        radio_clk;
    logic        bus_rst;
    wb_req_t     wb_req;
    logic        pps_gpsdo;
    logic        pps_ext;
    logic [1:0]  lock;
    logic [31:0] misc_in;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic [31:0] misc_out;
    logic        pps;

    integer         seed = 32'h8c16d554;
    int             error_count = 0;
    int             ack_seen = 0;
    int             cycle_count = 0;
    int             pps_high_seen = 0;
    logic           watch_pps = 1'b0;
    core_settings_t model;
    logic [31:0]    model_pps_count;
    string          name_q[$];
    logic [63:0]    exp_q[$];
    logic [63:0]    act_q[$];

    `include "b200_ctrl_checks.svh"

    b200_ctrl_top b200_ctrl_top_i (
        .radio_clk   (radio_clk),
        .bus_rst     (bus_rst),
        .i_wb        (wb_req),
        .i_pps_gpsdo (pps_gpsdo),
        .i_pps_ext   (pps_ext),
        .i_lock      (lock),
        .i_misc_in   (misc_in),
        .o_wb_dat    (wb_dat),
        .o_wb_ack    (wb_ack),
        .o_misc      (misc_out),
        .o_pps       (pps)
    );

    initial begin
        radio_clk = 1'b0;
        forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
    end

    always @(posedge radio_clk) cycle_count++;
    always @(negedge radio_clk) begin
        if (wb_ack) ack_seen++;
        if (watch_pps && pps) pps_high_seen++;   // Selected PPS seen high
    end

    // Compare process
    initial begin
        string       n;
        logic [63:0] e;
        logic [63:0] a;
        forever begin
            wait (act_q.size() != 0);
            n = name_q.pop_front();
            e = exp_q.pop_front();
            a = act_q.pop_front();
            compare_value(n, e, a);
        end
    end

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a test did not finish", NUM_TESTS * 2000);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog timeout");
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [31:0] data;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [63:0] word;
        int          start_cycle;
        int          exp_pulses;
        int          delta;
        bus_rst = 1'b1;
        wb_req = '0;
        pps_gpsdo = 1'b0;
        pps_ext = 1'b0;
        lock = 2'd0;
        misc_in = 32'd0;
        model = '0;
        model_pps_count = 32'd0;
        repeat (10) @(posedge radio_clk);
        #DRIVE_DLY bus_rst = 1'b0;

        // Reset values and signature word
        queue_check("reset misc output", 64'd0, misc_out);
        bus_read(REG_RB_HI, hi);
        bus_read(REG_RB_LO, lo);
        queue_check("signature word", expected_readback(2'd0, model, lock, misc_in,
                    model_pps_count), {hi, lo});

        // Setting registers read back
        for (int i = 0; i < 8; i++) begin
            data = $random(seed);
            write_and_verify(REG_MISC, data, 32'hFFFF_FFFF, "misc readback");
            model.misc = data;
            queue_check("misc output", data, misc_out);
            data = $random(seed);
            write_and_verify(REG_RB_SEL, data, 32'h3, "rb_sel readback");
            model.rb_sel = data[1:0];
            data = $random(seed);
            write_and_verify(REG_GPSDO_ST, data, 32'hFF, "gpsdo_st readback");
            model.gpsdo_st = data[7:0];
            data = $random(seed);
            write_and_verify(REG_PPS_SEL, data, 32'h3, "pps_sel readback");
            model.pps_sel = pps_src_e'(data[1:0]);
        end

        // Captured status words
        @(posedge radio_clk);
        #DRIVE_DLY;
        lock = 2'($random(seed));
        misc_in = $random(seed);
        repeat (4) @(posedge radio_clk);
        read_rb_word(2'd2, word);
        queue_check("status word", expected_readback(2'd2, model, lock, misc_in,
                    model_pps_count), word);
        read_rb_word(2'd3, word);
        queue_check("lock word", expected_readback(2'd3, model, lock, misc_in,
                    model_pps_count), word);

        // External PPS count after a fresh reset
        @(posedge radio_clk);
        #DRIVE_DLY bus_rst = 1'b1;
        repeat (10) @(posedge radio_clk);
        #DRIVE_DLY bus_rst = 1'b0;
        model.misc = 32'd0;
        model.pps_sel = PPS_GPSDO;   // gpsdo_st kept through reset
        read_rb_word(2'd2, word);
        queue_check("gpsdo_st after reset", expected_readback(2'd2, model, lock, misc_in,
                    model_pps_count), word);
        bus_write(REG_PPS_SEL, PPS_EXT);
        model.pps_sel = PPS_EXT;
        pps_high_seen = 0;
        watch_pps = 1'b1;
        drive_pulses(1'b1, 5);
        model_pps_count = 32'd5;
        drive_pulses(1'b0, 3);   // Not selected
        watch_pps = 1'b0;
        queue_check("external pps output", 64'd5, pps_high_seen);
        read_rb_word(2'd1, word);
        queue_check("external pps count", expected_readback(2'd1, model, lock, misc_in,
                    model_pps_count), word);

        // Internal PPS count with one pulse of slack for the unknown phase
        bus_write(REG_PPS_SEL, PPS_INT);
        model.pps_sel = PPS_INT;
        start_cycle = cycle_count;
        repeat (1000) @(posedge radio_clk);
        read_rb_word(2'd1, word);
        exp_pulses = (cycle_count - start_cycle) / 100;
        delta = word[31:0] - model_pps_count;
        queue_check("internal pps count", exp_pulses,
                    (delta >= exp_pulses - 1 && delta <= exp_pulses + 1) ? exp_pulses : delta);

        // No source selected
        bus_write(REG_PPS_SEL, PPS_OFF);
        model.pps_sel = PPS_OFF;
        read_rb_word(2'd1, word);
        model_pps_count = word[31:0];
        pps_high_seen = 0;
        watch_pps = 1'b1;
        drive_pulses(1'b1, 4);
        drive_pulses(1'b0, 4);
        watch_pps = 1'b0;
        queue_check("pps output while off", 64'd0, pps_high_seen);
        read_rb_word(2'd1, word);
        queue_check("count while off", expected_readback(2'd1, model, lock, misc_in,
                    model_pps_count), word);

        wait (act_q.size() == 0);
        @(posedge radio_clk);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
